/* hw/icache_cfg_pkg.sv */
/*
  Instruction cache geometry and the vector types used on the LCE ports.
  Block size and beat count must stay consistent (BLOCK_BYTES = 8 * BEATS_PER_BLOCK).
  TIMEOUT_LIMIT is the number of blocked cycles before the front end yields a cycle.
*/
`default_nettype none

package icache_cfg_pkg;

  typedef logic [31:0] paddr_t;
  typedef logic [63:0] dword_t;
  // 4 ways
  typedef logic [1:0]  way_t;
  typedef logic [1:0]  lce_id_t;
  // two directories
  typedef logic [0:0]  cce_id_t;

  localparam int unsigned BLOCK_BYTES     = 64;
  localparam int unsigned BEATS_PER_BLOCK = 8;
  localparam int unsigned TIMEOUT_LIMIT   = 4;

  // front end request kinds
  typedef enum logic [1:0] {
    miss_load = 2'b00,
    uc_load   = 2'b01,
    none      = 2'b10
  } cache_req_type_e;

endpackage

`default_nettype wire

/* hw/lce_cce_pkg.sv */
/*
  Message encodings between the instruction cache LCE and the directory (CCE).
  Only the request, response and command types used by the miss path exist here.
  Directory selection assumes two directories interleaved on block granularity.
  The msg_size_e encoding is log2 of the byte count minus 3.
*/
`default_nettype none

package lce_cce_pkg;

  // request types sent to the directory
  typedef enum logic [1:0] {
    req_rd    = 2'b00,
    req_uc_rd = 2'b01
  } lce_req_type_e;

  // response types, only the coherence ack is produced by this LCE
  typedef enum logic [1:0] {
    resp_none    = 2'b00,
    resp_coh_ack = 2'b01
  } lce_resp_type_e;

  // transfer size of a request
  typedef enum logic [2:0] {
    size_8   = 3'b000,
    size_16  = 3'b001,
    size_32  = 3'b010,
    size_64  = 3'b011,
    size_128 = 3'b100
  } msg_size_e;

  // full block fill, matches the 64 byte block of the cache
  localparam msg_size_e BLOCK_MSG_SIZE = size_64;

  // commands from the directory
  typedef enum logic [1:0] {
    cmd_set_tag        = 2'b00,
    cmd_set_tag_wakeup = 2'b01,
    cmd_data           = 2'b10,
    cmd_uc_data        = 2'b11
  } lce_cmd_type_e;

  // address bit that picks the owning directory
  localparam int unsigned CCE_SELECT_BIT = 6;

endpackage

`default_nettype wire

/* hw/lce_req_fsm.sv */
/*
  Request side of the icache LCE. Handles one outstanding miss or uncached load.
  The replacement way must arrive on cache_req_metadata_v_i after the request
  is accepted, and the request is not sent before it has been captured.
  cache_req_ready_o is low whenever the command buffer is not empty.
  A coherent fill ends with one coh_ack, an uncached load ends with no response.
*/
`timescale 1ns/1ps
`default_nettype none

module lce_req_fsm (
  input  wire logic                             clk_i,
  input  wire logic                             reset_i,
  input  wire icache_cfg_pkg::lce_id_t          lce_id_i,

  input  wire logic                             cache_req_v_i,
  input  wire icache_cfg_pkg::cache_req_type_e  cache_req_type_i,
  input  wire icache_cfg_pkg::paddr_t           cache_req_addr_i,
  output      logic                             cache_req_ready_o,
  input  wire logic                             cache_req_metadata_v_i,
  input  wire icache_cfg_pkg::way_t             cache_req_repl_way_i,
  output      icache_cfg_pkg::paddr_t           miss_addr_o,

  input  wire logic                             data_done_i,
  input  wire logic                             uc_data_done_i,
  input  wire logic                             set_tag_done_i,
  input  wire logic                             set_tag_wakeup_done_i,
  input  wire logic                             coherence_blocked_i,
  input  wire logic                             cmd_idle_i,

  output      logic                             lce_req_v_o,
  input  wire logic                             lce_req_ready_i,
  output      lce_cce_pkg::lce_req_type_e       lce_req_type_o,
  output      icache_cfg_pkg::paddr_t           lce_req_addr_o,
  output      lce_cce_pkg::msg_size_e           lce_req_size_o,
  output      icache_cfg_pkg::way_t             lce_req_lru_way_o,
  output      icache_cfg_pkg::lce_id_t          lce_req_src_o,
  output      icache_cfg_pkg::cce_id_t          lce_req_dst_o,

  output      logic                             lce_resp_v_o,
  input  wire logic                             lce_resp_yumi_i,
  output      lce_cce_pkg::lce_resp_type_e      lce_resp_type_o,
  output      icache_cfg_pkg::paddr_t           lce_resp_addr_o,
  output      icache_cfg_pkg::lce_id_t          lce_resp_src_o,
  output      icache_cfg_pkg::cce_id_t          lce_resp_dst_o
);

  typedef enum logic [2:0] {
    st_ready,
    st_send_miss,
    st_send_uc,
    st_sleep,
    st_send_ack
  } state_e;

  typedef logic [$clog2(icache_cfg_pkg::TIMEOUT_LIMIT + 1)-1:0] tcount_t;

  state_e                 state_r, state_n;
  icache_cfg_pkg::paddr_t miss_addr_r;
  icache_cfg_pkg::way_t   repl_way_r;
  logic                   md_v_r;
  logic                   data_seen_r, tag_seen_r;
  logic                   data_seen, tag_seen;
  logic                   req_accept;
  logic                   in_send, is_uc;
  tcount_t                timeout_cnt_r;
  logic                   timeout;

  assign req_accept = cache_req_v_i & cache_req_ready_o;

  always_comb begin
    state_n   = state_r;
    // an event in this cycle counts as already seen
    data_seen = data_seen_r | data_done_i;
    tag_seen  = tag_seen_r | set_tag_done_i;
    case (state_r)
      st_ready: begin
        if (req_accept) begin
          if (cache_req_type_i == icache_cfg_pkg::miss_load) begin
            state_n = st_send_miss;
          end else if (cache_req_type_i == icache_cfg_pkg::uc_load) begin
            state_n = st_send_uc;
          end
        end
      end
      st_send_miss, st_send_uc: begin
        if (lce_req_v_o) begin
          state_n = st_sleep;
        end
      end
      st_sleep: begin
        if (set_tag_wakeup_done_i) begin
          state_n = st_send_ack;
        end else if (uc_data_done_i) begin
          state_n = st_ready;
        end else if (data_seen && tag_seen) begin
          state_n = st_send_ack;
        end
      end
      st_send_ack: begin
        if (lce_resp_yumi_i) begin
          state_n = st_ready;
        end
      end
      default: state_n = st_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= st_ready;
      md_v_r      <= 1'b0;
      data_seen_r <= 1'b0;
      tag_seen_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      if (req_accept) begin
        md_v_r      <= 1'b0;
        data_seen_r <= 1'b0;
        tag_seen_r  <= 1'b0;
      end else begin
        // metadata comes one or more cycles after the request
        if (cache_req_metadata_v_i) begin
          md_v_r <= 1'b1;
        end
        data_seen_r <= data_seen;
        tag_seen_r  <= tag_seen;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      miss_addr_r <= cache_req_addr_i;
    end
    if (cache_req_metadata_v_i) begin
      repl_way_r <= cache_req_repl_way_i;
    end
  end

  // count consecutive cycles with a command stuck behind a busy cache
  always_ff @(posedge clk_i) begin
    if (reset_i || !coherence_blocked_i) begin
      timeout_cnt_r <= '0;
    end else if (!timeout) begin
      timeout_cnt_r <= timeout_cnt_r + 1'b1;
    end
  end

  assign timeout = (timeout_cnt_r == tcount_t'(icache_cfg_pkg::TIMEOUT_LIMIT));

  assign cache_req_ready_o = (state_r == st_ready) & cmd_idle_i & ~timeout;
  assign miss_addr_o       = miss_addr_r;

  assign is_uc   = (state_r == st_send_uc);
  assign in_send = (state_r == st_send_miss) | is_uc;

  // ready comes first, valid follows only with the way captured
  assign lce_req_v_o    = in_send & lce_req_ready_i & md_v_r;
  assign lce_req_type_o = is_uc ? lce_cce_pkg::req_uc_rd : lce_cce_pkg::req_rd;

  // uncached loads fetch the aligned dword
  assign lce_req_addr_o = is_uc
    ? (miss_addr_r & ~icache_cfg_pkg::paddr_t'($bits(icache_cfg_pkg::dword_t) / 8 - 1))
    : (miss_addr_r & ~icache_cfg_pkg::paddr_t'(icache_cfg_pkg::BLOCK_BYTES - 1));
  assign lce_req_size_o    = is_uc ? lce_cce_pkg::size_8 : lce_cce_pkg::BLOCK_MSG_SIZE;
  assign lce_req_lru_way_o = repl_way_r;
  assign lce_req_src_o     = lce_id_i;
  assign lce_req_dst_o     =
    icache_cfg_pkg::cce_id_t'(lce_req_addr_o[lce_cce_pkg::CCE_SELECT_BIT]);

  assign lce_resp_v_o    = (state_r == st_send_ack);
  assign lce_resp_type_o = lce_resp_v_o ? lce_cce_pkg::resp_coh_ack : lce_cce_pkg::resp_none;
  assign lce_resp_addr_o = miss_addr_r;
  assign lce_resp_src_o  = lce_id_i;
  assign lce_resp_dst_o  =
    icache_cfg_pkg::cce_id_t'(miss_addr_r[lce_cce_pkg::CCE_SELECT_BIT]);

  // exactly one request per miss, only from a send state
  a_req_once : assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_o |-> in_send ##1 (!lce_req_v_o && state_r == st_sleep));

  // response held with stable fields until the directory takes it
  a_resp_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_resp_v_o && !lce_resp_yumi_i) |=>
      (lce_resp_v_o && $stable(lce_resp_addr_o) && $stable(lce_resp_type_o)
       && $stable(lce_resp_dst_o)));

endmodule

`default_nettype wire

/* hw/lce_cmd_handler.sv */
/*
  Command side of the icache LCE. Buffers one directory command and writes it
  into the cache arrays as a single-cycle fill strobe once cache_busy_i is low.
  The cache has no ready, so cache_busy_i only delays the strobe.
  A data command is one beat, data_done fires on the last beat of a block.
*/
`timescale 1ns/1ps
`default_nettype none

module lce_cmd_handler (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  input  wire logic                          lce_cmd_v_i,
  output      logic                          lce_cmd_ready_o,
  input  wire lce_cce_pkg::lce_cmd_type_e    lce_cmd_type_i,
  input  wire icache_cfg_pkg::paddr_t        lce_cmd_addr_i,
  input  wire icache_cfg_pkg::way_t          lce_cmd_way_i,
  input  wire icache_cfg_pkg::dword_t        lce_cmd_data_i,

  input  wire logic                          cache_busy_i,
  output      logic                          fill_v_o,
  output      lce_cce_pkg::lce_cmd_type_e    fill_type_o,
  output      icache_cfg_pkg::paddr_t        fill_addr_o,
  output      icache_cfg_pkg::way_t          fill_way_o,
  output      icache_cfg_pkg::dword_t        fill_data_o,

  output      logic                          data_done_o,
  output      logic                          uc_data_done_o,
  output      logic                          set_tag_done_o,
  output      logic                          set_tag_wakeup_done_o,
  output      logic                          coherence_blocked_o,
  output      logic                          cmd_idle_o
);

  typedef logic [$clog2(icache_cfg_pkg::BEATS_PER_BLOCK)-1:0] beat_t;

  logic                       buf_v_r;
  lce_cce_pkg::lce_cmd_type_e buf_type_r;
  icache_cfg_pkg::paddr_t     buf_addr_r;
  icache_cfg_pkg::way_t       buf_way_r;
  icache_cfg_pkg::dword_t     buf_data_r;
  beat_t                      beat_cnt_r;
  logic                       cmd_accept;
  logic                       data_beat, last_beat;

  assign lce_cmd_ready_o = ~buf_v_r;
  assign cmd_accept      = lce_cmd_v_i & lce_cmd_ready_o;

  // entry is freed in the strobe cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_v_r <= 1'b0;
    end else if (cmd_accept) begin
      buf_v_r <= 1'b1;
    end else if (fill_v_o) begin
      buf_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      buf_type_r <= lce_cmd_type_i;
      buf_addr_r <= lce_cmd_addr_i;
      buf_way_r  <= lce_cmd_way_i;
      buf_data_r <= lce_cmd_data_i;
    end
  end

  assign data_beat = fill_v_o & (buf_type_r == lce_cce_pkg::cmd_data);
  assign last_beat = (beat_cnt_r == beat_t'(icache_cfg_pkg::BEATS_PER_BLOCK - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_cnt_r <= '0;
    end else if (data_beat) begin
      beat_cnt_r <= last_beat ? '0 : beat_cnt_r + 1'b1;
    end
  end

  assign fill_v_o    = buf_v_r & ~cache_busy_i;
  assign fill_type_o = buf_type_r;
  assign fill_addr_o = buf_addr_r;
  assign fill_way_o  = buf_way_r;
  assign fill_data_o = buf_data_r;

  // events go out with the strobe
  assign data_done_o           = data_beat & last_beat;
  assign uc_data_done_o        = fill_v_o & (buf_type_r == lce_cce_pkg::cmd_uc_data);
  assign set_tag_done_o        = fill_v_o & (buf_type_r == lce_cce_pkg::cmd_set_tag);
  assign set_tag_wakeup_done_o = fill_v_o & (buf_type_r == lce_cce_pkg::cmd_set_tag_wakeup);

  assign coherence_blocked_o = buf_v_r & cache_busy_i;
  assign cmd_idle_o          = ~buf_v_r;

  // no write into a busy cache, and a blocked command is still there next cycle
  a_no_fill_busy : assert property (@(posedge clk_i) disable iff (reset_i)
    (buf_v_r && cache_busy_i) |-> !fill_v_o ##1 (buf_v_r && $stable(fill_addr_o)));

endmodule

`default_nettype wire

/* hw/icache_lce.sv */
/*
  Instruction cache LCE miss path: request state machine plus command handler.
  One outstanding miss at a time, no invalidations or writebacks.
  The cache arrays and the directory sit outside this block.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_lce (
  input  wire logic                             clk_i,
  input  wire logic                             reset_i,
  input  wire icache_cfg_pkg::lce_id_t          lce_id_i,

  input  wire logic                             cache_req_v_i,
  input  wire icache_cfg_pkg::cache_req_type_e  cache_req_type_i,
  input  wire icache_cfg_pkg::paddr_t           cache_req_addr_i,
  output      logic                             cache_req_ready_o,
  input  wire logic                             cache_req_metadata_v_i,
  input  wire icache_cfg_pkg::way_t             cache_req_repl_way_i,
  output      icache_cfg_pkg::paddr_t           miss_addr_o,

  output      logic                             lce_req_v_o,
  input  wire logic                             lce_req_ready_i,
  output      lce_cce_pkg::lce_req_type_e       lce_req_type_o,
  output      icache_cfg_pkg::paddr_t           lce_req_addr_o,
  output      lce_cce_pkg::msg_size_e           lce_req_size_o,
  output      icache_cfg_pkg::way_t             lce_req_lru_way_o,
  output      icache_cfg_pkg::lce_id_t          lce_req_src_o,
  output      icache_cfg_pkg::cce_id_t          lce_req_dst_o,

  output      logic                             lce_resp_v_o,
  input  wire logic                             lce_resp_yumi_i,
  output      lce_cce_pkg::lce_resp_type_e      lce_resp_type_o,
  output      icache_cfg_pkg::paddr_t           lce_resp_addr_o,
  output      icache_cfg_pkg::lce_id_t          lce_resp_src_o,
  output      icache_cfg_pkg::cce_id_t          lce_resp_dst_o,

  input  wire logic                             lce_cmd_v_i,
  output      logic                             lce_cmd_ready_o,
  input  wire lce_cce_pkg::lce_cmd_type_e       lce_cmd_type_i,
  input  wire icache_cfg_pkg::paddr_t           lce_cmd_addr_i,
  input  wire icache_cfg_pkg::way_t             lce_cmd_way_i,
  input  wire icache_cfg_pkg::dword_t           lce_cmd_data_i,

  input  wire logic                             cache_busy_i,
  output      logic                             fill_v_o,
  output      lce_cce_pkg::lce_cmd_type_e       fill_type_o,
  output      icache_cfg_pkg::paddr_t           fill_addr_o,
  output      icache_cfg_pkg::way_t             fill_way_o,
  output      icache_cfg_pkg::dword_t           fill_data_o
);

  // events from the command side to the request side
  logic data_done, uc_data_done, set_tag_done, set_tag_wakeup_done;
  logic coherence_blocked, cmd_idle;

  lce_req_fsm u_req_fsm (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .lce_id_i              (lce_id_i),
    .cache_req_v_i         (cache_req_v_i),
    .cache_req_type_i      (cache_req_type_i),
    .cache_req_addr_i      (cache_req_addr_i),
    .cache_req_ready_o     (cache_req_ready_o),
    .cache_req_metadata_v_i(cache_req_metadata_v_i),
    .cache_req_repl_way_i  (cache_req_repl_way_i),
    .miss_addr_o           (miss_addr_o),
    .data_done_i           (data_done),
    .uc_data_done_i        (uc_data_done),
    .set_tag_done_i        (set_tag_done),
    .set_tag_wakeup_done_i (set_tag_wakeup_done),
    .coherence_blocked_i   (coherence_blocked),
    .cmd_idle_i            (cmd_idle),
    .lce_req_v_o           (lce_req_v_o),
    .lce_req_ready_i       (lce_req_ready_i),
    .lce_req_type_o        (lce_req_type_o),
    .lce_req_addr_o        (lce_req_addr_o),
    .lce_req_size_o        (lce_req_size_o),
    .lce_req_lru_way_o     (lce_req_lru_way_o),
    .lce_req_src_o         (lce_req_src_o),
    .lce_req_dst_o         (lce_req_dst_o),
    .lce_resp_v_o          (lce_resp_v_o),
    .lce_resp_yumi_i       (lce_resp_yumi_i),
    .lce_resp_type_o       (lce_resp_type_o),
    .lce_resp_addr_o       (lce_resp_addr_o),
    .lce_resp_src_o        (lce_resp_src_o),
    .lce_resp_dst_o        (lce_resp_dst_o)
  );

  lce_cmd_handler u_cmd_handler (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_cmd_v_i          (lce_cmd_v_i),
    .lce_cmd_ready_o      (lce_cmd_ready_o),
    .lce_cmd_type_i       (lce_cmd_type_i),
    .lce_cmd_addr_i       (lce_cmd_addr_i),
    .lce_cmd_way_i        (lce_cmd_way_i),
    .lce_cmd_data_i       (lce_cmd_data_i),
    .cache_busy_i         (cache_busy_i),
    .fill_v_o             (fill_v_o),
    .fill_type_o          (fill_type_o),
    .fill_addr_o          (fill_addr_o),
    .fill_way_o           (fill_way_o),
    .fill_data_o          (fill_data_o),
    .data_done_o          (data_done),
    .uc_data_done_o       (uc_data_done),
    .set_tag_done_o       (set_tag_done),
    .set_tag_wakeup_done_o(set_tag_wakeup_done),
    .coherence_blocked_o  (coherence_blocked),
    .cmd_idle_o           (cmd_idle)
  );

endmodule

`default_nettype wire

/* verification/icache_lce_tb.sv */
/*
  Testbench for the icache LCE miss path with a stand-in directory.
  Cases come from a table. One miss or uncached load is in flight at a time.
  Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge.
  Fill strobes are checked by a monitor against a queue of accepted commands.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_lce_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_CASES   = 7;
  localparam int WATCHDOG_NS = NUM_CASES * 200 * CLK_PERIOD;
  // directory reply orders
  localparam int TAG_FIRST   = 0;
  localparam int DATA_FIRST  = 1;
  localparam int WAKEUP      = 2;
  localparam icache_cfg_pkg::lce_id_t LCE_ID = 2'd1;

  typedef struct packed {
    icache_cfg_pkg::cache_req_type_e req_type;
    icache_cfg_pkg::paddr_t          addr;
    icache_cfg_pkg::way_t            way;
    int                              order;
    int                              busy_len;
    int                              yumi_delay;
  } case_t;

  typedef struct packed {
    lce_cce_pkg::lce_cmd_type_e t;
    icache_cfg_pkg::paddr_t     addr;
    icache_cfg_pkg::way_t       way;
    icache_cfg_pkg::dword_t     data;
  } fill_t;

  logic                            clk_i;
  logic                            reset_i;
  icache_cfg_pkg::lce_id_t         lce_id_i;
  logic                            cache_req_v_i;
  icache_cfg_pkg::cache_req_type_e cache_req_type_i;
  icache_cfg_pkg::paddr_t          cache_req_addr_i;
  logic                            cache_req_ready_o;
  logic                            cache_req_metadata_v_i;
  icache_cfg_pkg::way_t            cache_req_repl_way_i;
  icache_cfg_pkg::paddr_t          miss_addr_o;
  logic                            lce_req_v_o;
  logic                            lce_req_ready_i;
  lce_cce_pkg::lce_req_type_e      lce_req_type_o;
  icache_cfg_pkg::paddr_t          lce_req_addr_o;
  lce_cce_pkg::msg_size_e          lce_req_size_o;
  icache_cfg_pkg::way_t            lce_req_lru_way_o;
  icache_cfg_pkg::lce_id_t         lce_req_src_o;
  icache_cfg_pkg::cce_id_t         lce_req_dst_o;
  logic                            lce_resp_v_o;
  logic                            lce_resp_yumi_i;
  lce_cce_pkg::lce_resp_type_e     lce_resp_type_o;
  icache_cfg_pkg::paddr_t          lce_resp_addr_o;
  icache_cfg_pkg::lce_id_t         lce_resp_src_o;
  icache_cfg_pkg::cce_id_t         lce_resp_dst_o;
  logic                            lce_cmd_v_i;
  logic                            lce_cmd_ready_o;
  lce_cce_pkg::lce_cmd_type_e      lce_cmd_type_i;
  icache_cfg_pkg::paddr_t          lce_cmd_addr_i;
  icache_cfg_pkg::way_t            lce_cmd_way_i;
  icache_cfg_pkg::dword_t          lce_cmd_data_i;
  logic                            cache_busy_i;
  logic                            fill_v_o;
  lce_cce_pkg::lce_cmd_type_e      fill_type_o;
  icache_cfg_pkg::paddr_t          fill_addr_o;
  icache_cfg_pkg::way_t            fill_way_o;
  icache_cfg_pkg::dword_t          fill_data_o;

  case_t       cases [NUM_CASES];
  fill_t       expected_fills [$];
  fill_t       next_fill;
  int          errors;
  int          checks;
  int          busy_left;
  int          req_count;
  int          ack_count;
  int          resp_cycles;
  int          blocked_run;
  int unsigned seed_val;

  icache_lce u_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic flag_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_req(input lce_cce_pkg::lce_req_type_e t, input icache_cfg_pkg::paddr_t a,
                           input lce_cce_pkg::msg_size_e s, input icache_cfg_pkg::way_t w,
                           input icache_cfg_pkg::cce_id_t dst);
    checks++;
    if (lce_req_type_o !== t || lce_req_addr_o !== a || lce_req_size_o !== s
        || lce_req_lru_way_o !== w || lce_req_dst_o !== dst || lce_req_src_o !== LCE_ID) begin
      errors++;
      $display("mismatch at %0t ns: request got %0d %h %0d %0d %0d, expected %0d %h %0d %0d %0d",
               $time, lce_req_type_o, lce_req_addr_o, lce_req_size_o, lce_req_lru_way_o,
               lce_req_dst_o, t, a, s, w, dst);
    end
  endtask

  task automatic check_miss_addr(input icache_cfg_pkg::paddr_t a);
    checks++;
    if (miss_addr_o !== a) begin
      errors++;
      $display("mismatch at %0t ns: miss address got %h, expected %h", $time, miss_addr_o, a);
    end
  endtask

  task automatic check_resp(input lce_cce_pkg::lce_resp_type_e t, input icache_cfg_pkg::paddr_t a,
                            input icache_cfg_pkg::cce_id_t dst);
    checks++;
    if (lce_resp_type_o !== t || lce_resp_addr_o !== a || lce_resp_dst_o !== dst
        || lce_resp_src_o !== LCE_ID) begin
      errors++;
      $display("mismatch at %0t ns: response got %0d %h %0d, expected %0d %h %0d",
               $time, lce_resp_type_o, lce_resp_addr_o, lce_resp_dst_o, t, a, dst);
    end
  endtask

  task automatic check_fill(input lce_cce_pkg::lce_cmd_type_e t, input icache_cfg_pkg::paddr_t a,
                            input icache_cfg_pkg::way_t w, input icache_cfg_pkg::dword_t d);
    checks++;
    if (fill_type_o !== t || fill_addr_o !== a || fill_way_o !== w || fill_data_o !== d) begin
      errors++;
      $display("mismatch at %0t ns: fill got %0d %h %0d %h, expected %0d %h %0d %h",
               $time, fill_type_o, fill_addr_o, fill_way_o, fill_data_o, t, a, w, d);
    end
  endtask

  // advance to just after the next rising edge and drive cache_busy from busy_left
  task automatic tick();
    @(posedge clk_i);
    #1;
    cache_busy_i = (busy_left > 0);
    if (busy_left > 0) begin
      busy_left--;
    end
  endtask

  task automatic send_cmd(input lce_cce_pkg::lce_cmd_type_e t, input icache_cfg_pkg::paddr_t a,
                          input icache_cfg_pkg::way_t w, input icache_cfg_pkg::dword_t d,
                          input int busy_cycles);
    logic  taken;
    fill_t f;
    taken = 1'b0;
    while (!taken) begin
      tick();
      lce_cmd_v_i    = 1'b1;
      lce_cmd_type_i = t;
      lce_cmd_addr_i = a;
      lce_cmd_way_i  = w;
      lce_cmd_data_i = d;
      @(negedge clk_i);
      taken = lce_cmd_ready_o;
    end
    // busy starts the cycle after acceptance so the command is held
    if (busy_cycles > 0) begin
      busy_left = busy_cycles;
    end
    tick();
    lce_cmd_v_i = 1'b0;
    f.t    = t;
    f.addr = a;
    f.way  = w;
    f.data = d;
    expected_fills.push_back(f);
  endtask

  task automatic wait_fill();
    @(negedge clk_i);
    while (!fill_v_o) begin
      tick();
      @(negedge clk_i);
    end
  endtask

  task automatic load_cases();
    cases[0] = '{icache_cfg_pkg::miss_load, 32'h0000_1234, 2'd1, TAG_FIRST, 0, 0};
    cases[1] = '{icache_cfg_pkg::miss_load, 32'h8000_0fc8, 2'd3, DATA_FIRST, 2, 3};
    cases[2] = '{icache_cfg_pkg::uc_load, 32'h0000_2a5f, 2'd0, TAG_FIRST, 0, 0};
    cases[3] = '{icache_cfg_pkg::miss_load, 32'h1234_5678, 2'd2, WAKEUP, 6, 1};
    cases[4] = '{icache_cfg_pkg::uc_load, 32'hdead_bee4, 2'd1, TAG_FIRST, 5, 0};
    cases[5] = '{icache_cfg_pkg::miss_load, 32'h0000_0040, 2'd0, TAG_FIRST, 1, 2};
    cases[6] = '{icache_cfg_pkg::miss_load, 32'h7fff_ffc0, 2'd2, DATA_FIRST, 7, 0};
  endtask

  task automatic run_case(input int idx);
    case_t                   e;
    icache_cfg_pkg::paddr_t  exp_addr;
    icache_cfg_pkg::cce_id_t exp_dst;
    logic                    is_uc;
    logic                    done;
    int                      md_delay;
    int                      rdy_delay;
    int                      c;
    int                      b;
    int                      errs_before;
    e           = cases[idx];
    errs_before = errors;
    req_count   = 0;
    ack_count   = 0;
    resp_cycles = 0;
    is_uc       = (e.req_type == icache_cfg_pkg::uc_load);
    exp_addr    = is_uc ? {e.addr[31:3], 3'b000} : {e.addr[31:6], 6'b000000};
    exp_dst     = exp_addr[lce_cce_pkg::CCE_SELECT_BIT];

    done = 1'b0;
    while (!done) begin
      tick();
      cache_req_v_i    = 1'b1;
      cache_req_type_i = e.req_type;
      cache_req_addr_i = e.addr;
      @(negedge clk_i);
      done = cache_req_ready_o;
    end

    // stand-in directory stalls ready while the front end sends metadata late
    md_delay  = $urandom % 3;
    rdy_delay = $urandom % 4;
    c         = 0;
    done      = 1'b0;
    while (!done) begin
      tick();
      cache_req_v_i          = 1'b0;
      cache_req_type_i       = icache_cfg_pkg::none;
      cache_req_metadata_v_i = (c == md_delay);
      cache_req_repl_way_i   = (c == md_delay) ? e.way : ~e.way;
      lce_req_ready_i        = (c >= rdy_delay);
      @(negedge clk_i);
      if (lce_req_v_o) begin
        done = 1'b1;
        if (c <= md_delay || c < rdy_delay) begin
          flag_error("request sent before metadata and directory ready");
        end
        check_req(is_uc ? lce_cce_pkg::req_uc_rd : lce_cce_pkg::req_rd, exp_addr,
                  is_uc ? lce_cce_pkg::size_8 : lce_cce_pkg::size_64, e.way, exp_dst);
        check_miss_addr(e.addr);
      end
      c++;
    end
    tick();
    cache_req_metadata_v_i = 1'b0;
    lce_req_ready_i        = 1'b0;

    if (is_uc) begin
      send_cmd(lce_cce_pkg::cmd_uc_data, exp_addr, e.way, {$urandom, $urandom}, e.busy_len);
    end else if (e.order == WAKEUP) begin
      send_cmd(lce_cce_pkg::cmd_set_tag_wakeup, exp_addr, e.way, 64'd0, e.busy_len);
    end else begin
      if (e.order == TAG_FIRST) begin
        send_cmd(lce_cce_pkg::cmd_set_tag, exp_addr, e.way, 64'd0, e.busy_len);
      end
      for (b = 0; b < 8; b++) begin
        send_cmd(lce_cce_pkg::cmd_data, exp_addr + icache_cfg_pkg::paddr_t'(b * 8), e.way,
                 {$urandom, $urandom}, (e.order == DATA_FIRST && b == 0) ? e.busy_len : 0);
      end
      if (e.order == DATA_FIRST) begin
        send_cmd(lce_cce_pkg::cmd_set_tag, exp_addr, e.way, 64'd0, 0);
      end
    end
    wait_fill();

    if (is_uc) begin
      tick();
      @(negedge clk_i);
      if (!cache_req_ready_o) begin
        flag_error("front end not ready the cycle after uncached data");
      end
    end else begin
      // ack is due the cycle after the last event and is held until yumi
      for (c = 0; c <= e.yumi_delay; c++) begin
        tick();
        lce_resp_yumi_i = (c == e.yumi_delay);
        @(negedge clk_i);
        if (!lce_resp_v_o) begin
          flag_error("coherence ack missing or dropped before yumi");
        end else begin
          check_resp(lce_cce_pkg::resp_coh_ack, e.addr,
                     e.addr[lce_cce_pkg::CCE_SELECT_BIT]);
        end
      end
      tick();
      lce_resp_yumi_i = 1'b0;
      @(negedge clk_i);
      if (!cache_req_ready_o) begin
        flag_error("front end not ready the cycle after yumi");
      end
    end

    // a command held with no miss in flight still takes ready from the front end
    send_cmd(lce_cce_pkg::cmd_set_tag, exp_addr, e.way, 64'd0, e.busy_len);
    wait_fill();

    repeat (3) begin
      tick();
    end
    @(negedge clk_i);
    if (req_count != 1) begin
      flag_error($sformatf("%0d requests sent for one miss", req_count));
    end
    if (ack_count != (is_uc ? 0 : 1) || resp_cycles != (is_uc ? 0 : e.yumi_delay + 1)) begin
      flag_error($sformatf("wrong number of responses, %0d acks taken in %0d response cycles",
                           ack_count, resp_cycles));
    end
    $display("case %0d addr %h: %0d errors", idx, e.addr, errors - errs_before);
  endtask

  // fill strobes, request and response counts, held-command rules
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (lce_req_v_o) begin
        req_count++;
      end
      if (lce_resp_v_o) begin
        resp_cycles++;
      end
      if (lce_resp_v_o && lce_resp_yumi_i) begin
        ack_count++;
      end
      if (expected_fills.size() != 0 && cache_busy_i) begin
        blocked_run++;
      end else begin
        blocked_run = 0;
      end
      if (blocked_run > icache_cfg_pkg::TIMEOUT_LIMIT && cache_req_ready_o) begin
        flag_error("front end still ready after the blocked-cycle timeout");
      end else if (expected_fills.size() != 0 && cache_req_ready_o) begin
        flag_error("front end ready while a command is held");
      end
      if (fill_v_o && cache_busy_i) begin
        flag_error("fill strobe while the cache is busy");
      end
      if (fill_v_o) begin
        if (expected_fills.size() == 0) begin
          flag_error("fill strobe without a command");
        end else begin
          next_fill = expected_fills.pop_front();
          check_fill(next_fill.t, next_fill.addr, next_fill.way, next_fill.data);
        end
      end else if (expected_fills.size() != 0 && !cache_busy_i) begin
        flag_error("fill strobe missing while the cache is free");
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns, the DUT hung", $time);
    $display("test failed");
    $finish;
  end

  initial begin
    clk_i                  = 1'b0;
    reset_i                = 1'b1;
    lce_id_i               = LCE_ID;
    cache_req_v_i          = 1'b0;
    cache_req_type_i       = icache_cfg_pkg::none;
    cache_req_addr_i       = '0;
    cache_req_metadata_v_i = 1'b0;
    cache_req_repl_way_i   = '0;
    lce_req_ready_i        = 1'b0;
    lce_resp_yumi_i        = 1'b0;
    lce_cmd_v_i            = 1'b0;
    lce_cmd_type_i         = lce_cce_pkg::cmd_set_tag;
    lce_cmd_addr_i         = '0;
    lce_cmd_way_i          = '0;
    lce_cmd_data_i         = '0;
    cache_busy_i           = 1'b0;
    errors                 = 0;
    checks                 = 0;
    busy_left              = 0;
    blocked_run            = 0;
    seed_val               = $urandom(32'h46c1);
    load_cases();

    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    if (!cache_req_ready_o || lce_req_v_o || lce_resp_v_o || fill_v_o) begin
      flag_error("outputs not in their idle state after reset");
    end

    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end

    $display("%0d cases, %0d checks, %0d errors", NUM_CASES, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/icache_cfg_pkg.sv
hw/lce_cce_pkg.sv
hw/lce_req_fsm.sv
hw/lce_cmd_handler.sv
hw/icache_lce.sv
verification/icache_lce_tb.sv

/* Makefile */
# Verilator simulation of the icache LCE testbench

VERILATOR ?= verilator
TOP       ?= icache_lce_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
